// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --top-module pps_lock_tb -f vlog.f -o pps_lock_sim
	-./obj_dir/pps_lock_sim +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then \
		echo "simulation failed"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== common/dac_pkg.sv ====
package dac_pkg;

	typedef logic [15:0] dac_word_t;  // offset binary, as the DAC expects
	typedef logic signed [15:0] dac_signed_t;  // two's complement filter value

	// AD5662 frame: 6 don't-care bits, power-down field, data word
	localparam int FRAME_LEN = 24;
	localparam logic [1:0] PD_BITS = 2'b00;  // normal operation
	localparam int GAP_LEN = 2;  // clocks with sync high between frames

	typedef logic [FRAME_LEN-1:0] frame_t;
	typedef logic [$clog2(FRAME_LEN)-1:0] bit_idx_t;

	typedef enum logic [1:0] {
		SER_IDLE,
		SER_SHIFT,
		SER_GAP
	} ser_state_t;

endpackage

// ==== common/pps_pkg.sv ====
package pps_pkg;

	// nominal second in clocks, shortened for simulation
	localparam logic [31:0] COUNT_PERIOD = 32'd1000;

	// blanking time after an accepted pulse edge
	localparam logic [31:0] DEBOUNCE_LEN = COUNT_PERIOD / 4;

	localparam int PHASE_W = 12;
	localparam int COUNT_W = 11;  // holds 0 .. COUNT_PERIOD-1

	// capture window spans 256 counts either side of the alignment point
	localparam int WINDOW_LEN = 512;
	localparam int COUNT_INIT = WINDOW_LEN / 2;  // counter value on lock

	// PI gains as arithmetic right shifts
	localparam int KP_SHIFT = 4;
	localparam int KI_SHIFT = 0;

	typedef logic [COUNT_W-1:0] count_t;
	typedef logic signed [PHASE_W-1:0] phase_t;

	// {on, armed, raw phase}
	typedef logic [PHASE_W+1:0] status_t;

endpackage

// ==== logic/dac_serializer.sv ====
`timescale 1ns/1ps

module dac_serializer
	import dac_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      dac_stb,
	input  dac_word_t dac_word,
	output logic      credit_ret,
	output logic      dac_sclk,
	output logic      dac_sync_n,
	output logic      dac_din
);

	ser_state_t state;
	frame_t     frame;
	frame_t     shreg;
	bit_idx_t   bit_cnt;  // bit index while shifting, gap clocks afterwards

	assign frame = {6'b0, PD_BITS, dac_word};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= SER_IDLE;
			bit_cnt    <= '0;
			credit_ret <= 1'b0;
			dac_sclk   <= 1'b0;
			dac_sync_n <= 1'b1;
			dac_din    <= 1'b0;
		end else begin
			credit_ret <= 1'b0;
			case (state)
				SER_IDLE: begin
					if (dac_stb) begin
						state      <= SER_SHIFT;
						dac_sync_n <= 1'b0;
						dac_sclk   <= 1'b1;  // first bit goes out with the rising edge
						dac_din    <= frame[FRAME_LEN-1];
						bit_cnt    <= '0;
					end
				end
				SER_SHIFT: begin
					if (dac_sclk) begin
						dac_sclk <= 1'b0;  // DAC samples here
					end else if (bit_cnt == bit_idx_t'(FRAME_LEN - 1)) begin
						state      <= SER_GAP;
						dac_sync_n <= 1'b1;
						bit_cnt    <= '0;
					end else begin
						dac_sclk <= 1'b1;
						dac_din  <= shreg[FRAME_LEN-1];
						bit_cnt  <= bit_cnt + 1'b1;
					end
				end
				SER_GAP: begin
					if (bit_cnt == bit_idx_t'(GAP_LEN - 1)) begin
						state      <= SER_IDLE;
						credit_ret <= 1'b1;  // frame done, filter may send again
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: state <= SER_IDLE;
			endcase
		end
	end

	// remaining bits, MSB first
	always_ff @(posedge clk) begin
		if (state == SER_IDLE && dac_stb)
			shreg <= {frame[FRAME_LEN-2:0], 1'b0};
		else if (state == SER_SHIFT && !dac_sclk)
			shreg <= {shreg[FRAME_LEN-2:0], 1'b0};
	end

endmodule

// ==== logic/pps_edge_filter.sv ====
`timescale 1ns/1ps

module pps_edge_filter
	import pps_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic pps_in,
	output logic pps_edge
);

	logic   sync1;
	logic   sync2;
	logic   sync_d;  // previous synchronized level
	logic   rise;
	logic   blank;  // ignoring edges after an accepted one
	count_t blank_cnt;

	assign rise = sync2 & ~sync_d;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync1     <= 1'b0;
			sync2     <= 1'b0;
			sync_d    <= 1'b0;
			pps_edge  <= 1'b0;
			blank     <= 1'b0;
			blank_cnt <= '0;
		end else begin
			sync1    <= pps_in;
			sync2    <= sync1;
			sync_d   <= sync2;
			pps_edge <= rise & ~blank;

			if (rise && !blank) begin
				blank     <= 1'b1;
				blank_cnt <= '0;
			end else if (blank) begin
				// blanking fits in count_t, it is shorter than a period
				if (blank_cnt == count_t'(DEBOUNCE_LEN - 1))
					blank <= 1'b0;
				else
					blank_cnt <= blank_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== logic/pps_lock_top.sv ====
`timescale 1ns/1ps

module pps_lock_top
	import pps_pkg::*;
	import dac_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      pps_in,
	input  logic      run_request,
	input  logic      err_sign,
	input  dac_word_t dac_preset_val,
	output logic      dac_sclk,
	output logic      dac_sync_n,
	output logic      dac_din,
	output status_t   dsp_status,
	output logic      dsp_ovf,
	output logic      pps_out
);

	logic      pps_edge;
	logic      phase_stb;
	logic      preset_stb;
	phase_t    phase;
	logic      dac_stb;
	dac_word_t dac_word;
	logic      credit_ret;  // serializer back to filter

	pps_edge_filter edge_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.pps_in   (pps_in),
		.pps_edge (pps_edge)
	);

	phase_detector pd_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.pps_edge    (pps_edge),
		.run_request (run_request),
		.err_sign    (err_sign),
		.phase       (phase),
		.phase_stb   (phase_stb),
		.preset_stb  (preset_stb),
		.pps_out     (pps_out),
		.dsp_status  (dsp_status)
	);

	pps_loop_filter plf_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.phase_stb      (phase_stb),
		.phase          (phase),
		.preset_stb     (preset_stb),
		.dac_preset_val (dac_preset_val),
		.credit_ret     (credit_ret),
		.dac_stb        (dac_stb),
		.dac_word       (dac_word),
		.ovf            (dsp_ovf)
	);

	dac_serializer ser_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.dac_stb    (dac_stb),
		.dac_word   (dac_word),
		.credit_ret (credit_ret),
		.dac_sclk   (dac_sclk),
		.dac_sync_n (dac_sync_n),
		.dac_din    (dac_din)
	);

endmodule

// ==== loop_filter/pps_loop_filter.sv ====
`timescale 1ns/1ps

module pps_loop_filter
	import pps_pkg::*;
	import dac_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      phase_stb,
	input  phase_t    phase,
	input  logic      preset_stb,
	input  dac_word_t dac_preset_val,
	input  logic      credit_ret,
	output logic      dac_stb,
	output dac_word_t dac_word,
	output logic      ovf
);

	dac_signed_t        integ;
	dac_signed_t        prop_q;  // proportional term for stage 2
	dac_signed_t        out_sat;
	logic signed [16:0] int_sum;
	logic signed [16:0] out_sum;
	logic               int_ovf;
	logic               out_ovf;
	logic               st1_v;
	logic               pend;  // result held until a credit comes back
	logic               credit;

	function automatic dac_signed_t sat16(input logic signed [16:0] s);
		if (s[16] != s[15]) begin
			return s[16] ? 16'sh8000 : 16'sh7fff;
		end
		return s[15:0];
	endfunction

	assign int_sum = 17'(integ) + 17'(phase >>> KI_SHIFT);
	assign out_sum = 17'(integ) + 17'(prop_q);
	assign int_ovf = int_sum[16] ^ int_sum[15];
	assign out_ovf = out_sum[16] ^ out_sum[15];
	assign out_sat = sat16(out_sum);

	// stage 1: integrator, or preset load
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			integ <= '0;
			st1_v <= 1'b0;
		end else begin
			st1_v <= preset_stb | phase_stb;
			if (preset_stb)
				integ <= {~dac_preset_val[15], dac_preset_val[14:0]};
			else if (phase_stb)
				integ <= sat16(int_sum);
		end
	end

	always_ff @(posedge clk) begin
		if (preset_stb)
			prop_q <= '0;  // preset passes through unchanged
		else if (phase_stb)
			prop_q <= dac_signed_t'(phase >>> KP_SHIFT);
	end

	// stage 2: output register gated by the single credit
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dac_stb <= 1'b0;
			pend    <= 1'b0;
			credit  <= 1'b1;
			ovf     <= 1'b0;
		end else begin
			dac_stb <= 1'b0;
			if (st1_v || pend) begin
				if (credit) begin
					dac_stb <= 1'b1;
					credit  <= 1'b0;
					pend    <= 1'b0;
				end else begin
					pend <= 1'b1;
				end
			end
			if (credit_ret)
				credit <= 1'b1;

			if ((phase_stb && !preset_stb && int_ovf) || (st1_v && out_ovf))
				ovf <= 1'b1;  // sticky until reset
		end
	end

	// newest result overwrites a held one
	always_ff @(posedge clk) begin
		if (st1_v)
			dac_word <= {~out_sat[15], out_sat[14:0]};
	end

endmodule

// ==== phase_detector/phase_detector.sv ====
`timescale 1ns/1ps

module phase_detector
	import pps_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    pps_edge,
	input  logic    run_request,
	input  logic    err_sign,    // selects feedback polarity
	output phase_t  phase,
	output logic    phase_stb,
	output logic    preset_stb,
	output logic    pps_out,
	output status_t dsp_status
);

	count_t             count;
	logic               armed;
	logic               dsp_on;  // loop running
	logic               run_d;
	logic               edge_d;  // edge delayed so the aligned pulse reads COUNT_INIT
	logic               meas_pend;  // phase captured, waiting for window close
	logic [PHASE_W-1:0] phase_raw;
	logic               lock;
	logic               win;
	logic               meas;
	phase_t             diff;

	assign win  = count < count_t'(WINDOW_LEN);
	assign lock = pps_edge & armed;

	// the locking edge itself shows up on edge_d together with preset_stb
	assign meas = edge_d & dsp_on & ~preset_stb;
	assign diff = phase_t'(count) - phase_t'(COUNT_INIT);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count      <= '0;
			armed      <= 1'b0;
			dsp_on     <= 1'b0;
			run_d      <= 1'b0;
			edge_d     <= 1'b0;
			meas_pend  <= 1'b0;
			phase_raw  <= '0;
			phase_stb  <= 1'b0;
			preset_stb <= 1'b0;
			pps_out    <= 1'b0;
		end else begin
			if (lock)
				count <= count_t'(COUNT_INIT);  // re-align on the first armed pulse
			else if (count == count_t'(COUNT_PERIOD - 1))
				count <= '0;
			else
				count <= count + 1'b1;

			run_d      <= run_request;
			edge_d     <= pps_edge;
			pps_out    <= win;
			preset_stb <= lock;
			phase_stb  <= meas_pend & ~win;  // one clock after the window closes

			if (run_request && !run_d)
				armed <= 1'b1;
			if (lock) begin
				armed  <= 1'b0;
				dsp_on <= 1'b1;
			end

			if (edge_d)
				phase_raw <= PHASE_W'(count);

			if (meas && win)
				meas_pend <= 1'b1;
			else if (!win || !run_request)
				meas_pend <= 1'b0;

			// pulse outside the window means the loop lost track
			if (!run_request || (meas && !win))
				dsp_on <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (meas && win)
			phase <= err_sign ? -diff : diff;
	end

	assign dsp_status = {dsp_on, armed, phase_raw};

endmodule

// ==== testbench/pps_lock_assertions.sv ====
`timescale 1ns/1ps

module pps_lock_assertions
	import pps_pkg::*;
	import dac_pkg::*;
(
	input logic    clk,
	input logic    arst_n,
	input logic    dac_sclk,
	input logic    dac_sync_n,
	input logic    pps_out,
	input status_t dsp_status,
	input logic    dac_stb,
	input logic    credit_ret
);

	int         fail_cnt = 0;
	logic [7:0] low_cnt;  // clocks with sync low in this frame
	logic [7:0] high_cnt;  // saturating
	logic       busy;  // frame handed over, credit not back yet

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			low_cnt  <= '0;
			high_cnt <= '0;
			busy     <= 1'b0;
		end else begin
			if (!dac_sync_n) begin
				low_cnt  <= low_cnt + 8'd1;
				high_cnt <= '0;
			end else begin
				low_cnt <= '0;
				if (high_cnt != 8'hff)
					high_cnt <= high_cnt + 8'd1;
			end
			if (dac_stb)
				busy <= 1'b1;
			else if (credit_ret)
				busy <= 1'b0;
		end
	end

	reset_values: assert property (@(posedge clk) !arst_n |->
		(dac_sync_n && !dac_sclk && !pps_out && dsp_status == '0))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("outputs not at reset values during reset");
	end

	// two clocks per bit
	sync_low_len: assert property (@(posedge clk) disable iff (!arst_n)
		(dac_sync_n && low_cnt != '0) |-> low_cnt == 8'(2 * FRAME_LEN))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("dac_sync_n low for %0d clocks", low_cnt);
	end

	frame_gap: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(dac_sync_n) |-> high_cnt >= 8'(GAP_LEN))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("gap between frames too short");
	end

	one_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
		dac_stb |-> !busy)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("new DAC word sent while a frame is in flight");
	end

	sclk_idle: assert property (@(posedge clk) disable iff (!arst_n)
		dac_sync_n |-> !dac_sclk)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("dac_sclk high outside a frame");
	end

endmodule

bind pps_lock_top pps_lock_assertions asrt_i (
	.clk        (clk),
	.arst_n     (arst_n),
	.dac_sclk   (dac_sclk),
	.dac_sync_n (dac_sync_n),
	.pps_out    (pps_out),
	.dsp_status (dsp_status),
	.dac_stb    (dac_stb),
	.credit_ret (credit_ret)
);

// ==== testbench/pps_lock_tb.sv ====
`timescale 1ns/1ps

module pps_lock_tb;
	import pps_pkg::*;
	import dac_pkg::*;

	localparam int PERIOD = COUNT_PERIOD;
	localparam int TIMEOUT_CYCLES = 12 * PERIOD + 10;  // longest schedule plus reset

	logic      clk = 1'b0;
	logic      arst_n;
	logic      pps_in;
	logic      run_request;
	logic      err_sign;
	dac_word_t dac_preset_val;
	logic      dac_sclk;
	logic      dac_sync_n;
	logic      dac_din;
	logic      dsp_ovf;
	logic      pps_out;
	status_t   dsp_status;

	int     cyc = 0;
	int     errors = 0;
	int     nbits = 0;
	int     lock_cyc;  // cycle of the locking pulse (alignment point)
	int     integ_m;  // signed reference integrator
	logic   ovf_m;
	frame_t shift;
	frame_t frames[$];

	pps_lock_top dut_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.pps_in         (pps_in),
		.run_request    (run_request),
		.err_sign       (err_sign),
		.dac_preset_val (dac_preset_val),
		.dac_sclk       (dac_sclk),
		.dac_sync_n     (dac_sync_n),
		.dac_din        (dac_din),
		.dsp_status     (dsp_status),
		.dsp_ovf        (dsp_ovf),
		.pps_out        (pps_out)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc == TIMEOUT_CYCLES) begin
			$display("timeout: the run took more than %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	// rebuild frames from the bits the DAC takes on falling sclk
	always @(negedge dac_sclk) begin
		if (dac_sync_n === 1'b0) begin
			shift = {shift[FRAME_LEN-2:0], dac_din};
			nbits = nbits + 1;
			if (nbits == FRAME_LEN) begin
				frames.push_back(shift);
				nbits = 0;
			end
		end
	end

	function automatic int clamp16(input int v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return v;
	endfunction

	// one PI step per phase error, result as offset binary word
	function automatic dac_word_t model_update(input int ph);
		int s;
		int o;
		s = integ_m + (ph >>> KI_SHIFT);
		if (s != clamp16(s))
			ovf_m = 1'b1;
		integ_m = clamp16(s);
		o = integ_m + (ph >>> KP_SHIFT);
		if (o != clamp16(o))
			ovf_m = 1'b1;
		return dac_word_t'(clamp16(o) + 32768);
	endfunction

	task automatic check_equal(input string name, input int exp, input int act);
		assert (exp == act) else begin
			$display("ERR %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic step_to(input int target);
		while (cyc < target) begin
			@(posedge clk);
			#2;
		end
	endtask

	// glitch adds a bounce 60 clocks after the accepted rise
	task automatic send_pulse(input int at, input logic glitch);
		step_to(at);
		pps_in = 1'b1;
		step_to(at + 20);
		pps_in = 1'b0;
		if (glitch) begin
			step_to(at + 60);
			pps_in = 1'b1;
			step_to(at + 70);
			pps_in = 1'b0;
		end
	endtask

	task automatic expect_frame(input string name, input int idx, input dac_word_t exp);
		while (frames.size() <= idx)
			step_to(cyc + 1);
		check_equal(name, {6'b0, PD_BITS, exp}, frames[idx]);
	endtask

	task automatic update_at(input string name, input int k, input int off, input logic glitch);
		int idx;
		idx = frames.size();
		send_pulse(lock_cyc + k * PERIOD + off, glitch);
		expect_frame(name, idx, model_update(err_sign ? -off : off));
		step_to(cyc + 100);
		check_equal({name, " frame count"}, idx + 1, frames.size());
		check_equal({name, " raw phase"}, COUNT_INIT + off, dsp_status[PHASE_W-1:0]);
	endtask

	initial begin
		int off;
		dac_word_t preset;
		arst_n = 1'b1;
		pps_in = 1'b0;
		run_request = 1'b0;
		err_sign = 1'b0;
		dac_preset_val = '0;
		void'($urandom(32'hcf38aa97));
		#1 arst_n = 1'b0;
		step_to(5);
		check_true(dac_sync_n && !dac_sclk && !pps_out && dsp_status == '0,
			"outputs not at their reset values");
		step_to(10);
		arst_n = 1'b1;
		err_sign = 1'($urandom);
		preset = 16'h4000 + 16'($urandom % 32'h8000);
		dac_preset_val = preset;
		step_to(40);
		check_equal("idle status", 0, dsp_status);
		check_true(dac_sync_n, "DAC frame started without run_request");

		// arm, then lock on the next pulse
		run_request = 1'b1;
		step_to(cyc + 5);
		check_true(dsp_status[PHASE_W] && !dsp_status[PHASE_W+1], "run_request did not arm");
		lock_cyc = cyc;
		send_pulse(lock_cyc, 1'b0);
		step_to(lock_cyc + 30);
		check_true(dsp_status[PHASE_W+1] && !dsp_status[PHASE_W], "loop not running after lock");
		integ_m = int'(preset) - 32768;
		ovf_m = 1'b0;
		expect_frame("preset", 0, preset);

		for (int k = 1; k <= 3; k++) begin
			off = int'($urandom % 401) - 200;
			update_at("update", k, off, k == 2);
		end
		step_to(lock_cyc + 4 * PERIOD);
		check_true(pps_out, "window flag low at the alignment point");
		update_at("aligned", 4, 0, 1'b0);
		check_equal("aligned integrator", integ_m + 32768, frames[4][15:0]);
		check_equal("ovf after updates", ovf_m, dsp_ovf);

		off = 300 + int'($urandom % 150);  // past the window edge
		send_pulse(lock_cyc + 5 * PERIOD + off, 1'b0);
		check_true(!pps_out, "window flag high outside the window");
		step_to(cyc + 10);
		check_true(!dsp_status[PHASE_W+1], "on bit still set after out-of-window pulse");
		step_to(lock_cyc + 6 * PERIOD);
		check_equal("frames after loss", 5, frames.size());

		// relock with a preset near full scale
		run_request = 1'b0;
		step_to(cyc + 5);
		run_request = 1'b1;
		preset = 16'hfff0;
		dac_preset_val = preset;
		step_to(cyc + 5);
		lock_cyc = cyc;
		send_pulse(lock_cyc, 1'b0);
		integ_m = int'(preset) - 32768;
		expect_frame("relock preset", 5, preset);
		update_at("saturation", 1, err_sign ? -200 : 200, 1'b0);
		check_equal("saturated word", 16'hffff, frames[6][15:0]);
		check_equal("ovf flag", 1, dsp_ovf);

		run_request = 1'b0;
		step_to(cyc + 5);
		check_true(!dsp_status[PHASE_W+1], "on bit still set after run_request dropped");
		send_pulse(lock_cyc + 2 * PERIOD, 1'b0);
		step_to(lock_cyc + 2 * PERIOD + 500);
		check_equal("frames after stop", 7, frames.size());

		$display("errors: %0d testbench, %0d assertion", errors, dut_i.asrt_i.fail_cnt);
		if (errors == 0 && dut_i.asrt_i.fail_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
common/pps_pkg.sv
common/dac_pkg.sv
logic/pps_edge_filter.sv
phase_detector/phase_detector.sv
loop_filter/pps_loop_filter.sv
logic/dac_serializer.sv
logic/pps_lock_top.sv
testbench/pps_lock_assertions.sv
testbench/pps_lock_tb.sv
